//--- hdl/rv_fetch_pkg.sv
`default_nettype none

package rv_fetch_pkg;

    // machine word and instruction word
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;

    // major opcodes
    localparam logic [6:0] OPC_OP   = 7'b0110011;
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // M extension selectors
    localparam logic [6:0] F7_MULDIV = 7'b0000001;
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REMU   = 3'b111;

    typedef enum logic [1:0] {
        MD_MUL,
        MD_DIVU,
        MD_REMU
    } md_op_t;

    typedef enum logic [1:0] {
        KIND_PLAIN,
        KIND_MULDIV,
        KIND_JUMP
    } inst_kind_t;

    // sequencer states, one instruction per pass
    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT_INST,
        S_MD_REQ,
        S_MD_DROP,
        S_NEXT
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/fetch_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fetch_if;

    logic                fetch_start;
    rv_fetch_pkg::xlen_t fetch_addr;
    rv_fetch_pkg::inst_t fetch_inst;
    logic                fetch_done;

    modport seq (
        output fetch_start,
        output fetch_addr,
        input  fetch_inst,
        input  fetch_done
    );

    modport port (
        input  fetch_start,
        input  fetch_addr,
        output fetch_inst,
        output fetch_done
    );

endinterface

`default_nettype wire

//--- hdl/md_if.sv
`timescale 1ns/100ps
`default_nettype none

// four-phase req/ack link to the multiply/divide unit
interface md_if;

    logic                 md_req;
    rv_fetch_pkg::md_op_t md_op;
    rv_fetch_pkg::xlen_t  md_a;
    rv_fetch_pkg::xlen_t  md_b;
    logic                 md_ack;
    rv_fetch_pkg::xlen_t  md_result;

    modport seq (
        output md_req,
        output md_op,
        output md_a,
        output md_b,
        input  md_ack,
        input  md_result
    );

    modport unit (
        input  md_req,
        input  md_op,
        input  md_a,
        input  md_b,
        output md_ack,
        output md_result
    );

endinterface

`default_nettype wire

//--- hdl/fetch_port.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_port (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         imem_ack,
    input  wire rv_fetch_pkg::inst_t    imem_rdata,
    output logic                        imem_req,
    output rv_fetch_pkg::xlen_t         imem_addr,
    fetch_if.port                       fch
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_REQ,
        P_DROP
    } port_state_t;

    port_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= P_IDLE;
            imem_req       <= 1'b0;
            fch.fetch_done <= 1'b0;
        end else begin
            fch.fetch_done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (fch.fetch_start) begin
                        imem_req <= 1'b1;
                        state    <= P_REQ;
                    end
                end
                P_REQ: begin
                    // data is taken together with the ack
                    if (imem_ack) begin
                        imem_req <= 1'b0;
                        state    <= P_DROP;
                    end
                end
                P_DROP: begin
                    // bus idle again before the sequencer moves on
                    if (!imem_ack) begin
                        fch.fetch_done <= 1'b1;
                        state          <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == P_IDLE && fch.fetch_start) begin
            imem_addr <= fch.fetch_addr;
        end
        if (state == P_REQ && imem_ack) begin
            fch.fetch_inst <= imem_rdata;
        end
    end

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_req |=> !imem_req || $stable(imem_addr)
    );

    // memory must have finished the previous handshake
    a_no_req_on_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(imem_req) |-> !imem_ack
    );

endmodule

`default_nettype wire

//--- hdl/inst_classify.sv
`timescale 1ns/100ps
`default_nettype none

module inst_classify (
    input  wire rv_fetch_pkg::inst_t    inst,
    input  wire rv_fetch_pkg::xlen_t    pc,
    input  wire rv_fetch_pkg::xlen_t    rs1_data,
    output rv_fetch_pkg::inst_kind_t    kind,
    output rv_fetch_pkg::md_op_t        md_op,
    output rv_fetch_pkg::xlen_t         jump_target
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rv_fetch_pkg::xlen_t j_imm;
    rv_fetch_pkg::xlen_t i_imm;
    rv_fetch_pkg::xlen_t jal_target;
    rv_fetch_pkg::xlen_t jalr_target;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // J-type immediate is scrambled in the encoding
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign i_imm = {{20{inst[31]}}, inst[31:20]};

    assign jal_target  = pc + j_imm;
    // jalr clears bit 0 of the sum
    assign jalr_target = (rs1_data + i_imm) & ~32'h1;

    assign jump_target = (opcode == rv_fetch_pkg::OPC_JALR) ? jalr_target : jal_target;

    always_comb begin
        kind  = rv_fetch_pkg::KIND_PLAIN;
        md_op = rv_fetch_pkg::MD_MUL;
        case (opcode)
            rv_fetch_pkg::OPC_OP: begin
                if (funct7 == rv_fetch_pkg::F7_MULDIV) begin
                    case (funct3)
                        rv_fetch_pkg::F3_MUL: begin
                            kind  = rv_fetch_pkg::KIND_MULDIV;
                            md_op = rv_fetch_pkg::MD_MUL;
                        end
                        rv_fetch_pkg::F3_DIVU: begin
                            kind  = rv_fetch_pkg::KIND_MULDIV;
                            md_op = rv_fetch_pkg::MD_DIVU;
                        end
                        rv_fetch_pkg::F3_REMU: begin
                            kind  = rv_fetch_pkg::KIND_MULDIV;
                            md_op = rv_fetch_pkg::MD_REMU;
                        end
                        // mulh and signed divide fall through as plain
                        default: kind = rv_fetch_pkg::KIND_PLAIN;
                    endcase
                end
            end
            rv_fetch_pkg::OPC_JAL:  kind = rv_fetch_pkg::KIND_JUMP;
            rv_fetch_pkg::OPC_JALR: kind = rv_fetch_pkg::KIND_JUMP;
            default:                kind = rv_fetch_pkg::KIND_PLAIN;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/muldiv_unit.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit #(
    parameter int MD_ITER = 32
) (
    input  wire  clk,
    input  wire  rst_n,
    md_if.unit   md
);

    localparam int CNT_W = $clog2(MD_ITER + 1);

    typedef enum logic [1:0] {
        U_IDLE,
        U_RUN,
        U_DONE,
        U_ACK
    } unit_state_t;

    unit_state_t          state;
    logic [CNT_W-1:0]     cnt;
    rv_fetch_pkg::md_op_t op_q;
    // acc is product or partial remainder
    rv_fetch_pkg::xlen_t  acc;
    // opa is shifted multiplicand or dividend/quotient
    rv_fetch_pkg::xlen_t  opa;
    // opb is multiplier or divisor
    rv_fetch_pkg::xlen_t  opb;
    logic [32:0]          trial;

    assign trial = {acc, opa[31]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= U_IDLE;
            cnt       <= '0;
            md.md_ack <= 1'b0;
        end else begin
            case (state)
                U_IDLE: begin
                    if (md.md_req && !md.md_ack) begin
                        cnt   <= '0;
                        state <= U_RUN;
                    end
                end
                U_RUN: begin
                    if (cnt == CNT_W'(MD_ITER - 1)) begin
                        state <= U_DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                U_DONE: begin
                    md.md_ack <= 1'b1;
                    state     <= U_ACK;
                end
                U_ACK: begin
                    if (!md.md_req) begin
                        md.md_ack <= 1'b0;
                        state     <= U_IDLE;
                    end
                end
                default: state <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            U_IDLE: begin
                op_q <= md.md_op;
                acc  <= '0;
                opa  <= md.md_a;
                opb  <= md.md_b;
            end
            U_RUN: begin
                if (op_q == rv_fetch_pkg::MD_MUL) begin
                    if (opb[0]) begin
                        acc <= acc + opa;
                    end
                    opa <= opa << 1;
                    opb <= opb >> 1;
                end else if (trial >= {1'b0, opb}) begin
                    // a zero divisor always subtracts, leaving all ones and the dividend
                    acc <= trial[31:0] - opb;
                    opa <= {opa[30:0], 1'b1};
                end else begin
                    acc <= trial[31:0];
                    opa <= {opa[30:0], 1'b0};
                end
            end
            U_DONE: begin
                md.md_result <= (op_q == rv_fetch_pkg::MD_DIVU) ? opa : acc;
            end
            default: ;
        endcase
    end

    // operands have to stay put for the whole request
    a_operands_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        md.md_req |=> !md.md_req ||
            ($stable(md.md_op) && $stable(md.md_a) && $stable(md.md_b))
    );

endmodule

`default_nettype wire

//--- hdl/pc_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module pc_sequencer #(
    parameter rv_fetch_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire rv_fetch_pkg::inst_kind_t   kind,
    input  wire rv_fetch_pkg::xlen_t        jump_target,
    input  wire rv_fetch_pkg::md_op_t       md_op_in,
    input  wire rv_fetch_pkg::xlen_t        rs1_data,
    input  wire rv_fetch_pkg::xlen_t        rs2_data,
    output rv_fetch_pkg::xlen_t             pc,
    output logic                            retire_valid,
    output rv_fetch_pkg::xlen_t             retire_pc,
    output rv_fetch_pkg::inst_t             retire_inst,
    output rv_fetch_pkg::inst_kind_t        retire_kind,
    output rv_fetch_pkg::xlen_t             md_result,
    fetch_if.seq                            fch,
    md_if.seq                               md
);

    rv_fetch_pkg::seq_state_t state;
    rv_fetch_pkg::xlen_t      pc_next_q;
    logic                     inst_done;

    assign inst_done = (state == rv_fetch_pkg::S_WAIT_INST) && fch.fetch_done;

    // one-cycle start, pc doubles as the fetch address
    assign fch.fetch_start = (state == rv_fetch_pkg::S_FETCH);
    assign fch.fetch_addr  = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= rv_fetch_pkg::S_FETCH;
            pc           <= RESET_PC;
            retire_valid <= 1'b0;
            md.md_req    <= 1'b0;
        end else begin
            retire_valid <= 1'b0;
            case (state)
                rv_fetch_pkg::S_FETCH: begin
                    state <= rv_fetch_pkg::S_WAIT_INST;
                end
                rv_fetch_pkg::S_WAIT_INST: begin
                    if (fch.fetch_done) begin
                        if (kind == rv_fetch_pkg::KIND_MULDIV) begin
                            md.md_req <= 1'b1;
                            state     <= rv_fetch_pkg::S_MD_REQ;
                        end else begin
                            state <= rv_fetch_pkg::S_NEXT;
                        end
                    end
                end
                rv_fetch_pkg::S_MD_REQ: begin
                    if (md.md_ack) begin
                        md.md_req <= 1'b0;
                        state     <= rv_fetch_pkg::S_MD_DROP;
                    end
                end
                rv_fetch_pkg::S_MD_DROP: begin
                    // unit must be idle before the next request can go out
                    if (!md.md_ack) begin
                        state <= rv_fetch_pkg::S_NEXT;
                    end
                end
                rv_fetch_pkg::S_NEXT: begin
                    pc           <= pc_next_q;
                    retire_valid <= 1'b1;
                    state        <= rv_fetch_pkg::S_FETCH;
                end
                default: state <= rv_fetch_pkg::S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (inst_done) begin
            // next pc chosen here, held until S_NEXT
            if (kind == rv_fetch_pkg::KIND_JUMP) begin
                pc_next_q <= jump_target;
            end else begin
                pc_next_q <= pc + 32'd4;
            end
            retire_pc   <= pc;
            retire_inst <= fch.fetch_inst;
            retire_kind <= kind;
            md.md_op    <= md_op_in;
            md.md_a     <= rs1_data;
            md.md_b     <= rs2_data;
        end
        if (state == rv_fetch_pkg::S_MD_REQ && md.md_ack) begin
            md_result <= md.md_result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_fetch_top #(
    parameter rv_fetch_pkg::xlen_t RESET_PC = 32'h8000_0000,
    parameter int                  MD_ITER  = 32
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             imem_ack,
    input  wire rv_fetch_pkg::inst_t        imem_rdata,
    input  wire rv_fetch_pkg::xlen_t        rs1_data,
    input  wire rv_fetch_pkg::xlen_t        rs2_data,
    output logic                            imem_req,
    output rv_fetch_pkg::xlen_t             imem_addr,
    output logic                            retire_valid,
    output rv_fetch_pkg::xlen_t             retire_pc,
    output rv_fetch_pkg::inst_t             retire_inst,
    output rv_fetch_pkg::inst_kind_t        retire_kind,
    output rv_fetch_pkg::xlen_t             md_result
);

    rv_fetch_pkg::xlen_t      pc;
    rv_fetch_pkg::inst_kind_t kind;
    rv_fetch_pkg::md_op_t     md_op;
    rv_fetch_pkg::xlen_t      jump_target;

    fetch_if fch_bus ();
    md_if    md_bus ();

    pc_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .kind         (kind),
        .jump_target  (jump_target),
        .md_op_in     (md_op),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_kind  (retire_kind),
        .md_result    (md_result),
        .fch          (fch_bus.seq),
        .md           (md_bus.seq)
    );

    fetch_port u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .fch        (fch_bus.port)
    );

    // decode works on the word held by the fetch port
    inst_classify u_classify (
        .inst        (fch_bus.fetch_inst),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .kind        (kind),
        .md_op       (md_op),
        .jump_target (jump_target)
    );

    muldiv_unit #(
        .MD_ITER (MD_ITER)
    ) u_muldiv (
        .clk   (clk),
        .rst_n (rst_n),
        .md    (md_bus.unit)
    );

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
    parameter int                  N        = 12,
    parameter rv_fetch_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             imem_req,
    input  wire rv_fetch_pkg::xlen_t        imem_addr,
    input  wire                             retire_valid,
    input  wire rv_fetch_pkg::xlen_t        retire_pc,
    input  wire rv_fetch_pkg::inst_t        retire_inst,
    input  wire rv_fetch_pkg::inst_kind_t   retire_kind,
    input  wire rv_fetch_pkg::xlen_t        md_result,
    input  wire rv_fetch_pkg::inst_t        exp_inst   [N],
    input  wire rv_fetch_pkg::inst_kind_t   exp_kind   [N],
    input  wire rv_fetch_pkg::xlen_t        exp_next   [N],
    input  wire rv_fetch_pkg::xlen_t        exp_result [N],
    output int                              pass_count,
    output int                              fail_count,
    output int                              err_count,
    output int                              retire_count,
    output int                              req_count
);

    logic req_seen;
    // mismatches charged to the entry now in flight
    int   entry_errs;

    initial begin
        pass_count   = 0;
        fail_count   = 0;
        err_count    = 0;
        retire_count = 0;
        req_count    = 0;
        entry_errs   = 0;
        req_seen     = 1'b0;
    end

    // fetch address of row idx, row 0 starts at the reset pc
    function automatic rv_fetch_pkg::xlen_t expected_pc(input int idx);
        if (idx == 0) begin
            return RESET_PC;
        end
        return exp_next[idx - 1];
    endfunction

    task automatic flag_mismatch(input string field, input int entry,
                                 input rv_fetch_pkg::xlen_t got,
                                 input rv_fetch_pkg::xlen_t want);
        $display("FAIL t=%0t entry %0d %s got %h expected %h", $time, entry, field, got, want);
        err_count  = err_count + 1;
        entry_errs = entry_errs + 1;
    endtask

    task automatic check_retire();
        rv_fetch_pkg::inst_kind_t want_kind;
        if (retire_count >= N) begin
            $display("retire at pc %h with no table entry left", retire_pc);
            err_count = err_count + 1;
        end else begin
            want_kind = exp_kind[retire_count];
            if (retire_pc !== expected_pc(retire_count)) begin
                flag_mismatch("retire_pc", retire_count, retire_pc, expected_pc(retire_count));
            end
            if (retire_inst !== exp_inst[retire_count]) begin
                flag_mismatch("retire_inst", retire_count, retire_inst,
                              exp_inst[retire_count]);
            end
            if (retire_kind !== want_kind) begin
                flag_mismatch("retire_kind", retire_count, 32'(retire_kind), 32'(want_kind));
            end
            // md_result only moves on multiply/divide rows
            if (want_kind == rv_fetch_pkg::KIND_MULDIV &&
                md_result !== exp_result[retire_count]) begin
                flag_mismatch("md_result", retire_count, md_result, exp_result[retire_count]);
            end
            if (entry_errs == 0) begin
                pass_count = pass_count + 1;
            end else begin
                fail_count = fail_count + 1;
            end
            $display("entry %0d pc %h %s: %s", retire_count, retire_pc, want_kind.name(),
                     (entry_errs == 0) ? "ok" : "mismatch");
        end
        entry_errs   = 0;
        retire_count = retire_count + 1;
    endtask

    // sampled on the falling edge, away from the DUT register updates
    always @(negedge clk) begin
        if (!rst_n) begin
            req_seen = 1'b0;
        end else begin
            if (imem_req && !req_seen) begin
                if (req_count <= N) begin
                    if (imem_addr !== expected_pc(req_count)) begin
                        flag_mismatch("imem_addr", req_count, imem_addr, expected_pc(req_count));
                    end
                end
                req_count = req_count + 1;
            end
            req_seen = imem_req;
            if (retire_valid) begin
                check_retire();
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int N            = 12;
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;
    // a divide row needs about 40 cycles, slow memory adds a few more
    localparam int LIMIT_CYCLES = N * 60 + RESET_CYCLES;
    localparam rv_fetch_pkg::xlen_t RESET_PC = 32'h8000_0000;

    localparam rv_fetch_pkg::inst_kind_t K_PLAIN = rv_fetch_pkg::KIND_PLAIN;
    localparam rv_fetch_pkg::inst_kind_t K_MD    = rv_fetch_pkg::KIND_MULDIV;
    localparam rv_fetch_pkg::inst_kind_t K_JUMP  = rv_fetch_pkg::KIND_JUMP;

    typedef enum int {
        MEM_IDLE,
        MEM_DELAY,
        MEM_ACK
    } mem_phase_t;

    logic                     clk;
    logic                     rst_n;
    logic                     imem_ack;
    rv_fetch_pkg::inst_t      imem_rdata;
    rv_fetch_pkg::xlen_t      rs1_data;
    rv_fetch_pkg::xlen_t      rs2_data;
    logic                     imem_req;
    rv_fetch_pkg::xlen_t      imem_addr;
    logic                     retire_valid;
    rv_fetch_pkg::xlen_t      retire_pc;
    rv_fetch_pkg::inst_t      retire_inst;
    rv_fetch_pkg::inst_kind_t retire_kind;
    rv_fetch_pkg::xlen_t      md_result;

    // one row per instruction, in fetch order
    rv_fetch_pkg::inst_t      tbl_inst   [N];
    rv_fetch_pkg::xlen_t      tbl_rs1    [N];
    rv_fetch_pkg::xlen_t      tbl_rs2    [N];
    rv_fetch_pkg::inst_kind_t tbl_kind   [N];
    rv_fetch_pkg::xlen_t      tbl_next   [N];
    rv_fetch_pkg::xlen_t      tbl_result [N];

    mem_phase_t mem_phase;
    int         mem_idx;
    int         mem_wait;
    integer     seed;
    int         pass_count;
    int         fail_count;
    int         err_count;
    int         retire_count;
    int         req_count;

    rv_fetch_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_kind  (retire_kind),
        .md_result    (md_result)
    );

    tb_checker #(
        .N        (N),
        .RESET_PC (RESET_PC)
    ) u_check (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_kind  (retire_kind),
        .md_result    (md_result),
        .exp_inst     (tbl_inst),
        .exp_kind     (tbl_kind),
        .exp_next     (tbl_next),
        .exp_result   (tbl_result),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .err_count    (err_count),
        .retire_count (retire_count),
        .req_count    (req_count)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic add_entry(input int idx, input rv_fetch_pkg::inst_t inst,
                             input rv_fetch_pkg::xlen_t rs1, input rv_fetch_pkg::xlen_t rs2,
                             input rv_fetch_pkg::inst_kind_t kind,
                             input rv_fetch_pkg::xlen_t next_pc,
                             input rv_fetch_pkg::xlen_t result);
        tbl_inst[idx]   = inst;
        tbl_rs1[idx]    = rs1;
        tbl_rs2[idx]    = rs2;
        tbl_kind[idx]   = kind;
        tbl_next[idx]   = next_pc;
        tbl_result[idx] = result;
    endtask

    task automatic fill_table();
        // addi x1, x0, 5
        add_entry(0, 32'h0050_0093, 32'd0, 32'd0, K_PLAIN, 32'h8000_0004, 32'd0);
        // mul x3, x1, x2 with small, overflowing and all-ones operands
        add_entry(1, 32'h0220_81b3, 32'd7, 32'd6, K_MD, 32'h8000_0008, 32'd42);
        add_entry(2, 32'h0220_81b3, 32'h1234_5678, 32'h0001_0000, K_MD, 32'h8000_000c,
                  32'h5678_0000);
        add_entry(3, 32'h0220_81b3, 32'hffff_ffff, 32'hffff_ffff, K_MD, 32'h8000_0010,
                  32'd1);
        // divu and remu, then both by zero
        add_entry(4, 32'h0220_d1b3, 32'd100, 32'd7, K_MD, 32'h8000_0014, 32'd14);
        add_entry(5, 32'h0220_f1b3, 32'd100, 32'd7, K_MD, 32'h8000_0018, 32'd2);
        add_entry(6, 32'h0220_d1b3, 32'h0000_1234, 32'd0, K_MD, 32'h8000_001c, 32'hffff_ffff);
        add_entry(7, 32'h0220_f1b3, 32'hdead_beef, 32'd0, K_MD, 32'h8000_0020, 32'hdead_beef);
        // jal x1, +64 then jal x0, -48
        add_entry(8, 32'h0400_00ef, 32'd0, 32'd0, K_JUMP, 32'h8000_0060, 32'd0);
        add_entry(9, 32'hfd1f_f06f, 32'd0, 32'd0, K_JUMP, 32'h8000_0030, 32'd0);
        // jalr x0, 0x101(x5), odd sum gets bit 0 cleared
        add_entry(10, 32'h1012_8067, 32'h8000_0100, 32'd0, K_JUMP, 32'h8000_0200, 32'd0);
        // mulh is not handled by the unit
        add_entry(11, 32'h0220_91b3, 32'd3, 32'd5, K_PLAIN, 32'h8000_0204, 32'd0);
    endtask

    // instruction memory with a random 0 to 3 cycle answer delay
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_phase <= MEM_IDLE;
            mem_idx   <= 0;
            mem_wait  <= 0;
        end else begin
            case (mem_phase)
                MEM_IDLE: begin
                    if (imem_req && !imem_ack && mem_idx < N) begin
                        mem_wait  <= $unsigned($random(seed)) % 4;
                        mem_phase <= MEM_DELAY;
                    end
                end
                MEM_DELAY: begin
                    if (mem_wait == 0) begin
                        imem_ack   <= 1'b1;
                        imem_rdata <= tbl_inst[mem_idx];
                        rs1_data   <= tbl_rs1[mem_idx];
                        rs2_data   <= tbl_rs2[mem_idx];
                        mem_phase  <= MEM_ACK;
                    end else begin
                        mem_wait <= mem_wait - 1;
                    end
                end
                MEM_ACK: begin
                    if (!imem_req) begin
                        imem_ack  <= 1'b0;
                        mem_idx   <= mem_idx + 1;
                        mem_phase <= MEM_IDLE;
                    end
                end
                default: mem_phase <= MEM_IDLE;
            endcase
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        seed       = 32'h3e0bb93c;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // the fetch after the last row shows its next pc
        while (!(retire_count == N && req_count > N)) begin
            @(posedge clk);
        end
        $display("entries passed %0d, failed %0d, mismatches %0d",
                 pass_count, fail_count, err_count);
        if (pass_count == N && fail_count == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 2 * HALF_PERIOD);
        $display("timeout: run did not finish within %0d cycles, %0d of %0d entries retired",
                 LIMIT_CYCLES, retire_count, N);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/rv_fetch_pkg.sv
hdl/fetch_if.sv
hdl/md_if.sv
hdl/fetch_port.sv
hdl/inst_classify.sv
hdl/muldiv_unit.sv
hdl/pc_sequencer.sv
hdl/rv_fetch_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it.
# Exit status is 0 only when the run reports the pass message.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -Mdir obj_dir -o sim_tb -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
